/* verilog/axi_bridge_cfg.svh */
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// Bus field widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ID_BITS   4
`define AXI_LEN_BITS  4

// Shared SRAM depth in 32-bit words
`define MEM_WORDS 256

// Encoded burst lengths, beats minus one
`define IBURST_LEN 3
`define DBURST_LEN 0

`endif

/* verilog/axi_bridge_pkg.sv */
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_bridge_pkg;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    OP_SB = 2'd0,
    OP_SH = 2'd1,
    OP_SW = 2'd2
  } store_op_t;

  // Cache side request, held until done
  typedef struct packed {
    logic                      req;
    logic                      write;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_DATA_BITS-1:0] wdata;
    store_op_t                 op;
  } cache_req_t;

  typedef struct packed {
    logic                      done;
    logic [`AXI_DATA_BITS-1:0] rdata;
  } cache_rsp_t;

  // Master-driven side of the bus
  typedef struct packed {
    logic                      awvalid;
    logic [`AXI_ID_BITS-1:0]   awid;
    logic [`AXI_ADDR_BITS-1:0] awaddr;
    logic [`AXI_LEN_BITS-1:0]  awlen;
    logic                      wvalid;
    logic [`AXI_DATA_BITS-1:0] wdata;
    logic [`AXI_STRB_BITS-1:0] wstrb;
    logic                      wlast;
    logic                      bready;
    logic                      arvalid;
    logic [`AXI_ID_BITS-1:0]   arid;
    logic [`AXI_ADDR_BITS-1:0] araddr;
    logic [`AXI_LEN_BITS-1:0]  arlen;
    logic                      rready;
  } axi_req_t;

  // Slave-driven side of the bus
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [`AXI_ID_BITS-1:0]   bid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`AXI_ID_BITS-1:0]   rid;
    logic [`AXI_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rlast;
  } axi_rsp_t;

  localparam int ST_IDLE_BIT = 0;
  localparam int ST_AR_BIT   = 1;
  localparam int ST_R_BIT    = 2;
  localparam int ST_AW_BIT   = 3;
  localparam int ST_W_BIT    = 4;
  localparam int ST_B_BIT    = 5;

  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    ST_AR   = 6'b000010,
    ST_R    = 6'b000100,
    ST_AW   = 6'b001000,
    ST_W    = 6'b010000,
    ST_B    = 6'b100000
  } master_state_t;

endpackage

`default_nettype wire

/* verilog/axi_master_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axi_master_port #(
  parameter logic [`AXI_ID_BITS-1:0]  master_id = '0,
  parameter logic [`AXI_LEN_BITS-1:0] read_len  = `DBURST_LEN
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  axi_bridge_pkg::cache_req_t cache_req,
  output axi_bridge_pkg::cache_rsp_t cache_rsp,
  output axi_bridge_pkg::axi_req_t   bus_req,
  input  axi_bridge_pkg::axi_rsp_t   bus_rsp
);

  import axi_bridge_pkg::*;

  master_state_t state;
  master_state_t state_nxt;

  logic [`AXI_ADDR_BITS-1:0] addr_q;
  logic [`AXI_DATA_BITS-1:0] wdata_q;
  logic [`AXI_STRB_BITS-1:0] wstrb_q;
  logic [`AXI_STRB_BITS-1:0] strb_dec;
  logic [`AXI_LEN_BITS-1:0]  beat_cnt;

  logic start;
  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic last_beat;

  assign start = state[ST_IDLE_BIT] & cache_req.req;

  assign ar_hs = bus_req.arvalid & bus_rsp.arready;
  assign r_hs  = bus_req.rready & bus_rsp.rvalid;
  assign aw_hs = bus_req.awvalid & bus_rsp.awready;
  assign w_hs  = bus_req.wvalid & bus_rsp.wready;
  assign b_hs  = bus_req.bready & bus_rsp.bvalid;

  assign last_beat = r_hs & (beat_cnt == read_len);

  // Byte lanes from store type and low address bits
  always_comb begin
    case (cache_req.op)
      OP_SW: strb_dec = 4'b1111;
      OP_SH: strb_dec = cache_req.addr[1] ? 4'b1100 : 4'b0011;
      OP_SB: strb_dec = 4'b0001 << cache_req.addr[1:0];
      default: strb_dec = 4'b0000;
    endcase
  end

  // wdata arrives already lane aligned
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= cache_req.addr;
      wdata_q <= cache_req.wdata;
      wstrb_q <= strb_dec;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
    end else if (start) begin
      beat_cnt <= '0;
    end else if (r_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Completion always returns to idle so a held req is not reissued
  always_comb begin
    state_nxt = state;
    unique case (1'b1)
      state[ST_IDLE_BIT]: begin
        if (cache_req.req) begin
          state_nxt = cache_req.write ? ST_AW : ST_AR;
        end
      end
      state[ST_AR_BIT]: begin
        if (ar_hs) begin
          state_nxt = ST_R;
        end
      end
      state[ST_R_BIT]: begin
        if (last_beat) begin
          state_nxt = ST_IDLE;
        end
      end
      state[ST_AW_BIT]: begin
        if (aw_hs) begin
          state_nxt = ST_W;
        end
      end
      state[ST_W_BIT]: begin
        if (w_hs) begin
          state_nxt = ST_B;
        end
      end
      state[ST_B_BIT]: begin
        if (b_hs) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_comb begin
    bus_req         = '0;
    bus_req.awid    = master_id;
    bus_req.awaddr  = addr_q;
    bus_req.awlen   = '0;
    bus_req.wdata   = wdata_q;
    bus_req.wstrb   = wstrb_q;
    bus_req.wlast   = 1'b1;
    bus_req.arid    = master_id;
    bus_req.araddr  = addr_q;
    bus_req.arlen   = read_len;
    bus_req.awvalid = state[ST_AW_BIT];
    bus_req.wvalid  = state[ST_W_BIT];
    bus_req.bready  = state[ST_B_BIT];
    bus_req.arvalid = state[ST_AR_BIT];
    bus_req.rready  = state[ST_R_BIT];
  end

  // One pulse per read beat, one per write response
  assign cache_rsp.done  = (state[ST_R_BIT] & bus_rsp.rvalid) |
                           (state[ST_B_BIT] & bus_rsp.bvalid);
  assign cache_rsp.rdata = bus_rsp.rdata;

endmodule

`default_nettype wire

/* verilog/axi_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bus_arbiter (
  input  logic                     clk,
  input  logic                     rstn,
  input  axi_bridge_pkg::axi_req_t m0_req,
  input  axi_bridge_pkg::axi_req_t m1_req,
  output axi_bridge_pkg::axi_rsp_t m0_rsp,
  output axi_bridge_pkg::axi_rsp_t m1_rsp,
  output axi_bridge_pkg::axi_req_t s_req,
  input  axi_bridge_pkg::axi_rsp_t s_rsp
);

  // grant also remembers the last winner once busy drops
  logic grant;
  logic busy;

  logic m0_want;
  logic m1_want;
  logic next_grant;
  logic cur_grant;
  logic addr_hs;
  logic done_hs;

  assign m0_want = m0_req.arvalid | m0_req.awvalid;
  assign m1_want = m1_req.arvalid | m1_req.awvalid;

  // On a tie the previous loser wins
  assign next_grant = (m0_want & m1_want) ? ~grant : m1_want;

  // Selection is live only between transactions
  assign cur_grant = busy ? grant : next_grant;

  // Losing master sees no request forwarded, so its valids never reach the slave
  assign s_req = cur_grant ? m1_req : m0_req;

  // Losing master gets all-inactive response, readies low
  always_comb begin
    m0_rsp = '0;
    m1_rsp = '0;
    if (cur_grant) begin
      m1_rsp = s_rsp;
    end else begin
      m0_rsp = s_rsp;
    end
  end

  assign addr_hs = (s_req.arvalid & s_rsp.arready) |
                   (s_req.awvalid & s_rsp.awready);

  assign done_hs = (s_rsp.rvalid & s_req.rready & s_rsp.rlast) |
                   (s_rsp.bvalid & s_req.bready);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      grant <= 1'b0;
      busy  <= 1'b0;
    end else if (!busy) begin
      if (addr_hs) begin
        grant <= next_grant;
        busy  <= 1'b1;
      end
    end else if (done_hs) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/axi_sram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axi_sram_slave (
  input  logic                     clk,
  input  logic                     rstn,
  input  axi_bridge_pkg::axi_req_t bus_req,
  output axi_bridge_pkg::axi_rsp_t bus_rsp
);

  import axi_bridge_pkg::*;

  localparam int IDX_BITS = $clog2(`MEM_WORDS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE,
    S_RESP
  } slave_state_t;

  slave_state_t state;

  logic [`AXI_DATA_BITS-1:0] mem [`MEM_WORDS];
  logic [IDX_BITS-1:0]       idx;
  logic [`AXI_LEN_BITS-1:0]  len_q;
  logic [`AXI_LEN_BITS-1:0]  beat_cnt;
  logic [`AXI_ID_BITS-1:0]   id_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  always_comb begin
    bus_rsp         = '0;
    bus_rsp.awready = (state == S_IDLE);
    // Write wins if both address channels show up together
    bus_rsp.arready = (state == S_IDLE) & ~bus_req.awvalid;
    bus_rsp.wready  = (state == S_WRITE);
    bus_rsp.bvalid  = (state == S_RESP);
    bus_rsp.bid     = id_q;
    bus_rsp.bresp   = AXI_RESP_OKAY;
    bus_rsp.rvalid  = (state == S_READ);
    bus_rsp.rid     = id_q;
    bus_rsp.rdata   = mem[idx];
    bus_rsp.rresp   = AXI_RESP_OKAY;
    bus_rsp.rlast   = (state == S_READ) & (beat_cnt == len_q);
  end

  assign ar_hs = bus_req.arvalid & bus_rsp.arready;
  assign r_hs  = bus_req.rready & bus_rsp.rvalid;
  assign aw_hs = bus_req.awvalid & bus_rsp.awready;
  assign w_hs  = bus_req.wvalid & bus_rsp.wready;
  assign b_hs  = bus_req.bready & bus_rsp.bvalid;

  // Word index, bumped per beat for incrementing bursts
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      idx   <= bus_req.awaddr[IDX_BITS+1:2];
      len_q <= '0;
      id_q  <= bus_req.awid;
    end else if (ar_hs) begin
      idx   <= bus_req.araddr[IDX_BITS+1:2];
      len_q <= bus_req.arlen;
      id_q  <= bus_req.arid;
    end else if (r_hs) begin
      idx <= idx + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= S_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          beat_cnt <= '0;
          if (aw_hs) begin
            state <= S_WRITE;
          end else if (ar_hs) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (bus_rsp.rlast) begin
              state <= S_IDLE;
            end
          end
        end
        S_WRITE: begin
          if (w_hs) begin
            state <= S_RESP;
          end
        end
        default: begin
          if (b_hs) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  // Only strobed lanes are written
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (w_hs) begin
      for (int b = 0; b < `AXI_STRB_BITS; b++) begin
        if (bus_req.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module mem_subsys_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  axi_bridge_pkg::cache_req_t i_req,
  output axi_bridge_pkg::cache_rsp_t i_rsp,
  input  axi_bridge_pkg::cache_req_t d_req,
  output axi_bridge_pkg::cache_rsp_t d_rsp
);

  import axi_bridge_pkg::*;

  axi_req_t m0_req;
  axi_req_t m1_req;
  axi_req_t s_req;
  axi_rsp_t m0_rsp;
  axi_rsp_t m1_rsp;
  axi_rsp_t s_rsp;

  // Instruction side, four-beat bursts
  axi_master_port #(
    .master_id (`AXI_ID_BITS'(0)),
    .read_len  (`AXI_LEN_BITS'(`IBURST_LEN))
  ) u_imaster (
    .clk       (clk),
    .rstn      (rstn),
    .cache_req (i_req),
    .cache_rsp (i_rsp),
    .bus_req   (m0_req),
    .bus_rsp   (m0_rsp)
  );

  // Data side, single beats with strobes
  axi_master_port #(
    .master_id (`AXI_ID_BITS'(1)),
    .read_len  (`AXI_LEN_BITS'(`DBURST_LEN))
  ) u_dmaster (
    .clk       (clk),
    .rstn      (rstn),
    .cache_req (d_req),
    .cache_rsp (d_rsp),
    .bus_req   (m1_req),
    .bus_rsp   (m1_rsp)
  );

  axi_bus_arbiter u_arbiter (
    .clk    (clk),
    .rstn   (rstn),
    .m0_req (m0_req),
    .m1_req (m1_req),
    .m0_rsp (m0_rsp),
    .m1_rsp (m1_rsp),
    .s_req  (s_req),
    .s_rsp  (s_rsp)
  );

  axi_sram_slave u_sram (
    .clk     (clk),
    .rstn    (rstn),
    .bus_req (s_req),
    .bus_rsp (s_rsp)
  );

endmodule

`default_nettype wire

/* verification/mem_subsys_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module mem_subsys_properties (
  input logic                     clk,
  input logic                     rstn,
  input axi_bridge_pkg::axi_req_t m0_req,
  input axi_bridge_pkg::axi_req_t m1_req,
  input axi_bridge_pkg::axi_rsp_t m0_rsp,
  input axi_bridge_pkg::axi_rsp_t m1_rsp,
  input axi_bridge_pkg::axi_rsp_t s_rsp,
  input logic                     grant,
  input logic                     busy
);

  // Address valids wait out back-pressure with a steady address
  m0_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    m0_req.arvalid && !m0_rsp.arready |=> m0_req.arvalid && $stable(m0_req.araddr))
    else $error("master 0 arvalid or araddr changed before arready");
  m1_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    m1_req.arvalid && !m1_rsp.arready |=> m1_req.arvalid && $stable(m1_req.araddr))
    else $error("master 1 arvalid or araddr changed before arready");
  m1_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    m1_req.awvalid && !m1_rsp.awready |=> m1_req.awvalid && $stable(m1_req.awaddr))
    else $error("master 1 awvalid or awaddr changed before awready");

  m0_rsp_granted: assert property (@(posedge clk) disable iff (!rstn)
    m0_rsp.rvalid || m0_rsp.bvalid |-> busy && !grant)
    else $error("response valid routed to master 0 without its grant");
  m1_rsp_granted: assert property (@(posedge clk) disable iff (!rstn)
    m1_rsp.rvalid || m1_rsp.bvalid |-> busy && grant)
    else $error("response valid routed to master 1 without its grant");

  rid_match: assert property (@(posedge clk) disable iff (!rstn)
    s_rsp.rvalid |-> s_rsp.rid == `AXI_ID_BITS'(grant))
    else $error("rid does not match the granted master");
  bid_match: assert property (@(posedge clk) disable iff (!rstn)
    s_rsp.bvalid |-> s_rsp.bid == `AXI_ID_BITS'(grant))
    else $error("bid does not match the granted master");

endmodule

bind axi_bus_arbiter mem_subsys_properties u_props (
  .clk    (clk),
  .rstn   (rstn),
  .m0_req (m0_req),
  .m1_req (m1_req),
  .m0_rsp (m0_rsp),
  .m1_rsp (m1_rsp),
  .s_rsp  (s_rsp),
  .grant  (grant),
  .busy   (busy)
);

`default_nettype wire

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module mem_subsys_tb;

  import axi_bridge_pkg::*;

  // Roughly 40 cycles for each request issued, with headroom
  localparam int MAX_CYCLES = 20000;
  // Own latency plus one four-beat burst of the other port
  localparam int WAIT_LIMIT = 10;

  logic       clk;
  logic       rstn;
  cache_req_t i_req;
  cache_rsp_t i_rsp;
  cache_req_t d_req;
  cache_rsp_t d_rsp;

  logic [31:0] model [`MEM_WORDS];
  logic [15:0] lfsr;
  int          cycles;
  int          checks;
  int          errors;
  int          mark_checks;
  int          mark_errors;

  mem_subsys_top u_mem_subsys_top (
    .clk   (clk),
    .rstn  (rstn),
    .i_req (i_req),
    .i_rsp (i_rsp),
    .d_req (d_req),
    .d_rsp (d_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Byte lanes a store touches
  function automatic logic [3:0] lane_mask(input store_op_t op, input logic [1:0] off);
    logic [3:0] m;
    for (int b = 0; b < 4; b++) begin
      case (op)
        OP_SW: m[b] = 1'b1;
        OP_SH: m[b] = (b / 2 == int'(off[1]));
        default: m[b] = (b == int'(off));
      endcase
    end
    return m;
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_wait_bound(input string port, input int waited);
    checks++;
    if (waited > WAIT_LIMIT) begin
      errors++;
      $display("%s port waited %0d cycles for its first response, more than %0d",
               port, waited, WAIT_LIMIT);
    end
  endtask

  task automatic check_no_done(input string what);
    checks++;
    if (i_rsp.done || d_rsp.done) begin
      errors++;
      $display("[ERROR] %0t %s: done high with no transaction", $time, what);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  task automatic d_access(input logic write, input logic [7:0] idx, input logic [1:0] off,
                          input logic [31:0] wdata, input store_op_t op);
    int         waited;
    logic [3:0] mask;
    mask = lane_mask(op, off);
    @(negedge clk);
    d_req.req   = 1'b1;
    d_req.write = write;
    d_req.addr  = {22'd0, idx, off};
    d_req.wdata = wdata;
    d_req.op    = op;
    waited = 1;
    @(negedge clk);
    while (!d_rsp.done) begin
      @(negedge clk);
      waited++;
    end
    check_wait_bound("data", waited);
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          model[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end else begin
      compare_word("data read", d_rsp.rdata, model[idx]);
    end
    d_req.req = 1'b0;
    @(negedge clk);
    checks++;
    if (d_rsp.done) begin
      errors++;
      $display("[ERROR] %0t data port: extra done pulse", $time);
    end
  endtask

  // Four-word aligned burst starting at word {blk, 2'b00}
  task automatic i_burst(input logic [5:0] blk);
    int waited;
    int beat;
    @(negedge clk);
    i_req.req   = 1'b1;
    i_req.write = 1'b0;
    i_req.addr  = {22'd0, blk, 4'b0000};
    i_req.wdata = '0;
    i_req.op    = OP_SW;
    waited = 0;
    beat   = 0;
    while (beat < 4) begin
      @(negedge clk);
      if (beat == 0) begin
        waited++;
      end
      if (i_rsp.done) begin
        if (beat == 0) begin
          check_wait_bound("instruction", waited);
        end
        compare_word("instruction beat", i_rsp.rdata, model[{blk, 2'(beat)}]);
        beat++;
      end
    end
    i_req.req = 1'b0;
    @(negedge clk);
    checks++;
    if (i_rsp.done) begin
      errors++;
      $display("[ERROR] %0t instruction port: more than four done pulses", $time);
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    logic [7:0]  idx;
    logic [1:0]  off;
    logic [31:0] wd;
    store_op_t   op;
    logic [5:0]  c_blk [40];
    logic        c_wr [40];
    logic [7:0]  c_idx [40];
    logic [31:0] c_wd [40];
    rstn        = 1'b0;
    i_req       = '0;
    d_req       = '0;
    lfsr        = 16'd21002;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model[i] = '0;
    end

    repeat (8) begin
      @(negedge clk);
      check_no_done("in reset");
    end
    rstn = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_no_done("after reset");
    end
    report_test("reset");

    for (int n = 0; n < 60; n++) begin
      idx = 8'(rand_bits(6));
      wd  = rand_bits(32);
      d_access(1'b1, idx, 2'b00, wd, OP_SW);
      idx = 8'(rand_bits(6));
      d_access(1'b0, idx, 2'b00, '0, OP_SW);
    end
    report_test("word traffic");

    for (int n = 0; n < 60; n++) begin
      op  = rand_bits(1) ? OP_SH : OP_SB;
      idx = 8'(rand_bits(8));
      off = 2'(rand_bits(2));
      if (op == OP_SH) begin
        off[0] = 1'b0;
      end
      wd = rand_bits(32);
      d_access(1'b1, idx, off, wd, op);
      d_access(1'b0, idx, 2'b00, '0, OP_SW);
    end
    report_test("byte and half stores");

    repeat (30) begin
      i_burst(6'(rand_bits(6)));
    end
    report_test("instruction bursts");

    // Requests for both sides of the contention round
    for (int n = 0; n < 40; n++) begin
      c_blk[n] = 6'(rand_bits(6));
      c_wr[n]  = rand_bits(1) ? 1'b1 : 1'b0;
      c_idx[n] = 8'(rand_bits(8));
      c_wd[n]  = rand_bits(32);
    end
    fork
      begin : i_side
        for (int n = 0; n < 40; n++) begin
          i_burst(c_blk[n]);
        end
      end
      begin : d_side
        for (int n = 0; n < 40; n++) begin
          d_access(c_wr[n], c_idx[n], 2'b00, c_wd[n], OP_SW);
        end
      end
    join
    report_test("contention");

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_subsys_top.f */
+incdir+verilog
verilog/axi_bridge_pkg.sv
verilog/axi_master_port.sv
verilog/axi_bus_arbiter.sv
verilog/axi_sram_slave.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_properties.sv
verification/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f mem_subsys_top.f \
  --top-module mem_subsys_tb \
  -o mem_subsys_sim

./obj_dir/mem_subsys_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation ok"
  exit 0
fi
echo "simulation reported a failure"
exit 1
